/* common/activeListCfgPkg.sv */
// ============================================================================
// Size constants and index types for the reorder buffer.
// Module parameters take their defaults from here, and the derived
// types carry the index, occupancy and lane-count widths.
// ============================================================================
`default_nettype none

package activeListCfgPkg;

    localparam int ENTRY_NUM = 16;
    localparam int DISPATCH_WIDTH = 2;
    localparam int WB_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;

    // Derived widths
    localparam int IDX_WIDTH = $clog2(ENTRY_NUM);
    localparam int COUNT_WIDTH = $clog2(ENTRY_NUM + 1);
    localparam int LANE_WIDTH = $clog2(COMMIT_WIDTH + 1);
    localparam int PC_WIDTH = 32;

    typedef logic [IDX_WIDTH-1:0] EntryIdx;

    // 0 to ENTRY_NUM inclusive
    typedef logic [COUNT_WIDTH-1:0] EntryCount;

    // Lanes acting in one cycle
    typedef logic [LANE_WIDTH-1:0] LaneCount;

    typedef logic [PC_WIDTH-1:0] PcWord;

endpackage

`default_nettype wire

/* common/activeListOpsPkg.sv */
// ============================================================================
// Execution-state and recovery-phase encodings and the entry record.
// Import next to activeListCfgPkg wherever entry contents are handled.
// ============================================================================
`default_nettype none

package activeListOpsPkg;

    // State written back by the execution units
    typedef enum logic [2:0] {
        stateNotFinished = 3'd0,
        stateSuccess     = 3'd1,
        stateRefetchThis = 3'd2,
        stateRefetchNext = 3'd3,
        stateTrap        = 3'd4
    } ExecState;

    typedef enum logic {
        phaseCommit = 1'b0,
        phaseFlush  = 1'b1
    } RecoveryPhase;

    typedef struct packed {
        activeListCfgPkg::PcWord pc;
        ExecState state;
    } EntryRecord;

    // Anything that finished but did not succeed needs recovery
    function automatic logic isFault(ExecState s);
        return !(s inside {stateNotFinished, stateSuccess});
    endfunction

endpackage

`default_nettype wire

/* common/activeListIf.sv */
// ============================================================================
// Internal buses of the reorder buffer.
// allocIf carries tail writes and pointers from the allocator to the entry
// store; headIf carries the head window from the store to commit logic.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

interface allocIf
    import activeListCfgPkg::*;
#(
    parameter int DISPATCH_WIDTH = activeListCfgPkg::DISPATCH_WIDTH
);
    logic pushValid [DISPATCH_WIDTH];
    EntryIdx pushIdx [DISPATCH_WIDTH];
    PcWord pushPc [DISPATCH_WIDTH];
    EntryIdx headPtr;
    EntryCount count;

    modport alloc (
        output pushValid, pushIdx, pushPc, headPtr, count
    );

    modport store (
        input pushValid, pushIdx, pushPc, headPtr, count
    );
endinterface

interface headIf
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int COMMIT_WIDTH = activeListCfgPkg::COMMIT_WIDTH
);
    // Lane i holds entry headPtr + i
    ExecState headState [COMMIT_WIDTH];
    PcWord headPc [COMMIT_WIDTH];
    EntryIdx headPtr;
    EntryCount count;

    modport store (
        output headState, headPc, headPtr, count
    );

    modport commit (
        input headState, headPc, headPtr, count
    );
endinterface

`default_nettype wire

/* activeList/dispatchAllocator.sv */
// ============================================================================
// Head, tail and occupancy pointers of the reorder buffer.
// Grants consecutive tail slots to valid dispatch lanes in lane order,
// retires popNum entries at the head, and empties the queue on flush.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module dispatchAllocator
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int ENTRY_NUM = activeListCfgPkg::ENTRY_NUM,
    parameter int DISPATCH_WIDTH = activeListCfgPkg::DISPATCH_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic dispatchValid [DISPATCH_WIDTH],
    input wire PcWord dispatchPc [DISPATCH_WIDTH],
    input wire LaneCount popNum,
    input wire logic flush,
    output logic allocatable,
    output EntryIdx dispatchIdx [DISPATCH_WIDTH],
    allocIf.alloc alloc
);

    EntryIdx headPtr;
    EntryIdx tailPtr;
    EntryCount count;
    LaneCount pushNum;
    RecoveryPhase phaseView;

    // Pointer plus a small offset, wrapped at ENTRY_NUM
    function automatic EntryIdx wrapAdd(EntryIdx base, LaneCount n);
        int sum;
        sum = int'(base) + int'(n);
        if (sum >= ENTRY_NUM) begin
            sum = sum - ENTRY_NUM;
        end
        return EntryIdx'(sum);
    endfunction

    // flush is high exactly while the commit side is in its flush phase
    assign phaseView = flush ? phaseFlush : phaseCommit;
    assign allocatable = (int'(count) <= ENTRY_NUM - DISPATCH_WIDTH)
                         && (phaseView == phaseCommit);

    always_comb begin
        pushNum = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispatchIdx[i] = wrapAdd(tailPtr, pushNum);
            alloc.pushValid[i] = dispatchValid[i];
            alloc.pushIdx[i] = dispatchIdx[i];
            alloc.pushPc[i] = dispatchPc[i];
            if (dispatchValid[i]) begin
                pushNum = pushNum + LaneCount'(1);
            end
        end
        alloc.headPtr = headPtr;
        alloc.count = count;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else if (flush) begin
            // Drop everything behind the head
            tailPtr <= headPtr;
            count <= '0;
        end else begin
            headPtr <= wrapAdd(headPtr, popNum);
            tailPtr <= wrapAdd(tailPtr, pushNum);
            count <= count + EntryCount'(pushNum) - EntryCount'(popNum);
        end
    end

endmodule

`default_nettype wire

/* activeList/completionTracker.sv */
// ============================================================================
// Entry store of the reorder buffer.
// Writes dispatched entries and execution writebacks, keeps the oldest
// faulting live entry, and presents the head window to the commit logic.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module completionTracker
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int ENTRY_NUM = activeListCfgPkg::ENTRY_NUM,
    parameter int DISPATCH_WIDTH = activeListCfgPkg::DISPATCH_WIDTH,
    parameter int WB_WIDTH = activeListCfgPkg::WB_WIDTH,
    parameter int COMMIT_WIDTH = activeListCfgPkg::COMMIT_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic wbValid [WB_WIDTH],
    input wire EntryIdx wbIdx [WB_WIDTH],
    input wire ExecState wbState [WB_WIDTH],
    allocIf.store store,
    headIf.store head,
    output logic pendingFaultValid,
    output EntryIdx pendingFaultIdx
);

    EntryRecord entries [ENTRY_NUM];

    logic pendValid;
    EntryIdx pendIdx;
    logic nextPendValid;
    EntryIdx nextPendIdx;

    // Distance from the head, i.e. how old an entry is
    function automatic int ageOf(EntryIdx idx, EntryIdx headPtr);
        int d;
        d = int'(idx) - int'(headPtr);
        if (d < 0) begin
            d = d + ENTRY_NUM;
        end
        return d;
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (store.pushValid[i]) begin
                entries[store.pushIdx[i]].pc <= store.pushPc[i];
                entries[store.pushIdx[i]].state <= stateNotFinished;
            end
        end
        // Writebacks only hit live entries, never a slot being pushed
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (wbValid[i]) begin
                entries[wbIdx[i]].state <= wbState[i];
            end
        end
    end

    // Oldest fault among the recorded one and this cycle's writebacks
    always_comb begin
        int bestAge;
        int age;
        nextPendValid = pendValid;
        nextPendIdx = pendIdx;
        bestAge = ageOf(pendIdx, store.headPtr);
        for (int i = 0; i < WB_WIDTH; i++) begin
            age = ageOf(wbIdx[i], store.headPtr);
            if (wbValid[i] && isFault(wbState[i])) begin
                if (!nextPendValid || age < bestAge) begin
                    nextPendValid = 1'b1;
                    nextPendIdx = wbIdx[i];
                    bestAge = age;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || store.count == '0) begin
            pendValid <= 1'b0;
            pendIdx <= '0;
        end else begin
            pendValid <= nextPendValid;
            pendIdx <= nextPendIdx;
        end
    end

    // An empty queue right after a flush holds no fault
    assign pendingFaultValid = pendValid && (store.count != '0);
    assign pendingFaultIdx = pendIdx;

    always_comb begin
        int slot;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            slot = int'(store.headPtr) + i;
            if (slot >= ENTRY_NUM) begin
                slot = slot - ENTRY_NUM;
            end
            head.headState[i] = entries[slot].state;
            head.headPc[i] = entries[slot].pc;
        end
        head.headPtr = store.headPtr;
        head.count = store.count;
    end

endmodule

`default_nettype wire

/* activeList/commitSelector.sv */
// ============================================================================
// In-order commit and fault recovery of the reorder buffer.
// Commits the leading successful entries of the head window, reports a
// fault at the head and runs the one-cycle flush phase that follows it.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module commitSelector
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int COMMIT_WIDTH = activeListCfgPkg::COMMIT_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    headIf.commit head,
    output logic commitValid [COMMIT_WIDTH],
    output PcWord commitPc [COMMIT_WIDTH],
    output logic faultValid,
    output PcWord faultPc,
    output ExecState faultState,
    output LaneCount popNum,
    output logic flush
);

    RecoveryPhase phase;
    logic headLive;

    // Lane 0 only counts when the queue holds something
    assign headLive = (head.count != '0);

    always_comb begin
        logic goOn;
        goOn = (phase == phaseCommit);
        popNum = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            // Stop at count or at the first entry not yet successful
            commitValid[i] = goOn
                             && (i < int'(head.count))
                             && (head.headState[i] == stateSuccess);
            commitPc[i] = head.headPc[i];
            goOn = commitValid[i];
            if (commitValid[i]) begin
                popNum = popNum + LaneCount'(1);
            end
        end
    end

    // A faulting head never commits, lane 0 fails the success check
    assign faultValid = (phase == phaseCommit) && headLive
                        && isFault(head.headState[0]);
    assign faultPc = head.headPc[0];
    assign faultState = head.headState[0];

    assign flush = (phase == phaseFlush);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phaseCommit;
        end else begin
            case (phase)
                phaseCommit: begin
                    if (faultValid) begin
                        phase <= phaseFlush;
                    end
                end
                phaseFlush: begin
                    // Queue is emptied at the end of this cycle
                    phase <= phaseCommit;
                end
                default: begin
                    phase <= phaseCommit;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/activeListTop.sv */
// ============================================================================
// Reorder buffer top level with plain ports.
// Connects the dispatch allocator, the completion tracker and the commit
// selector, and sets the queue size and lane counts for all of them.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module activeListTop
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int ENTRY_NUM = activeListCfgPkg::ENTRY_NUM,
    parameter int DISPATCH_WIDTH = activeListCfgPkg::DISPATCH_WIDTH,
    parameter int WB_WIDTH = activeListCfgPkg::WB_WIDTH,
    parameter int COMMIT_WIDTH = activeListCfgPkg::COMMIT_WIDTH
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic dispatchValid [DISPATCH_WIDTH],
    input wire PcWord dispatchPc [DISPATCH_WIDTH],
    input wire logic wbValid [WB_WIDTH],
    input wire EntryIdx wbIdx [WB_WIDTH],
    input wire ExecState wbState [WB_WIDTH],
    output logic allocatable,
    output EntryIdx dispatchIdx [DISPATCH_WIDTH],
    output logic commitValid [COMMIT_WIDTH],
    output PcWord commitPc [COMMIT_WIDTH],
    output logic faultValid,
    output PcWord faultPc,
    output ExecState faultState,
    output logic pendingFaultValid,
    output EntryIdx pendingFaultIdx,
    output EntryCount validEntryNum
);

    LaneCount popNum;
    logic flush;

    allocIf #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) allocBus ();
    headIf #(.COMMIT_WIDTH(COMMIT_WIDTH)) headBus ();

    dispatchAllocator #(
        .ENTRY_NUM(ENTRY_NUM),
        .DISPATCH_WIDTH(DISPATCH_WIDTH)
    ) allocator (
        .clk(clk), .rst(rst),
        .dispatchValid(dispatchValid), .dispatchPc(dispatchPc),
        .popNum(popNum), .flush(flush),
        .allocatable(allocatable), .dispatchIdx(dispatchIdx),
        .alloc(allocBus.alloc)
    );

    completionTracker #(
        .ENTRY_NUM(ENTRY_NUM),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .WB_WIDTH(WB_WIDTH),
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) tracker (
        .clk(clk), .rst(rst),
        .wbValid(wbValid), .wbIdx(wbIdx), .wbState(wbState),
        .store(allocBus.store), .head(headBus.store),
        .pendingFaultValid(pendingFaultValid), .pendingFaultIdx(pendingFaultIdx)
    );

    commitSelector #(
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) selector (
        .clk(clk), .rst(rst),
        .head(headBus.commit),
        .commitValid(commitValid), .commitPc(commitPc),
        .faultValid(faultValid), .faultPc(faultPc), .faultState(faultState),
        .popNum(popNum), .flush(flush)
    );

    // Occupancy straight from the pointer block
    assign validEntryNum = allocBus.count;

endmodule

`default_nettype wire

/* verif/activeList_checker.sv */
// ============================================================================
// Concurrent checks on occupancy and the recovery phase of the reorder
// buffer, bound into the commit selector where phase and faults live.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module activeList_checker
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
#(
    parameter int ENTRY_NUM = activeListCfgPkg::ENTRY_NUM
) (
    input wire logic clk,
    input wire logic rst,
    input wire EntryCount count,
    input wire RecoveryPhase phase,
    input wire logic faultValid,
    input wire logic anyCommit
);

    // Occupancy comes from the allocator through headIf
    countInRange: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= ENTRY_NUM)
        else $error("Occupancy above the number of entries");

    faultStartsFlush: assert property (@(posedge clk) disable iff (rst)
        faultValid |=> phase == phaseFlush)
        else $error("Fault at the head not followed by the flush phase");

    // The allocator empties the queue at the end of the flush cycle
    flushEmptiesQueue: assert property (@(posedge clk) disable iff (rst)
        phase == phaseFlush |=> phase == phaseCommit && count == '0)
        else $error("Flush phase longer than one cycle or queue not emptied");

    // Commits are contiguous, so lane 0 covers every lane
    noCommitInFlush: assert property (@(posedge clk) disable iff (rst)
        phase == phaseFlush |-> !anyCommit)
        else $error("Commit during the flush phase");

endmodule

bind commitSelector activeList_checker phaseCheck (
    .clk(clk),
    .rst(rst),
    .count(head.count),
    .phase(phase),
    .faultValid(faultValid),
    .anyCommit(commitValid[0])
);

`default_nettype wire

/* verif/activeListTb.sv */
// ============================================================================
// Testbench for the reorder buffer top level.
// Drives seeded random dispatches and writebacks, follows the queue in a
// reference model and compares the DUT outputs in the middle of each cycle.
// ============================================================================
`timescale 1ns/1ns
`default_nettype none

module activeListTb
    import activeListCfgPkg::*;
    import activeListOpsPkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES = 4000;
    localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2;
    localparam logic [31:0] SEED = 32'hc258;

    logic clk;
    logic rst;
    logic dispatchValid [DISPATCH_WIDTH];
    PcWord dispatchPc [DISPATCH_WIDTH];
    logic wbValid [WB_WIDTH];
    EntryIdx wbIdx [WB_WIDTH];
    ExecState wbState [WB_WIDTH];
    logic allocatable;
    EntryIdx dispatchIdx [DISPATCH_WIDTH];
    logic commitValid [COMMIT_WIDTH];
    PcWord commitPc [COMMIT_WIDTH];
    logic faultValid;
    PcWord faultPc;
    ExecState faultState;
    logic pendingFaultValid;
    EntryIdx pendingFaultIdx;
    EntryCount validEntryNum;

    // Reference model with element 0 of each queue at the head
    PcWord modelPc [$];
    ExecState modelState [$];
    int modelHead;
    int modelTail;
    logic modelFlush;
    int expPop;
    logic expFault;
    PcWord nextPc;
    int commitTotal;
    int flushTotal;

    activeListTop dut0 (
        .clk(clk), .rst(rst),
        .dispatchValid(dispatchValid), .dispatchPc(dispatchPc),
        .wbValid(wbValid), .wbIdx(wbIdx), .wbState(wbState),
        .allocatable(allocatable), .dispatchIdx(dispatchIdx),
        .commitValid(commitValid), .commitPc(commitPc),
        .faultValid(faultValid), .faultPc(faultPc), .faultState(faultState),
        .pendingFaultValid(pendingFaultValid), .pendingFaultIdx(pendingFaultIdx),
        .validEntryNum(validEntryNum)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test loop finished");
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout");
    end

    // Finished but not successful
    function automatic logic modelFault(ExecState s);
        return (s != stateNotFinished) && (s != stateSuccess);
    endfunction

    function automatic ExecState pickWbState();
        if ($urandom_range(19, 0) != 0) begin
            return stateSuccess;
        end
        case ($urandom_range(2, 0))
            0: return stateRefetchThis;
            1: return stateRefetchNext;
            default: return stateTrap;
        endcase
    endfunction

    task automatic checkEqual(input longint actual, input longint expected, input string what);
        if (actual != expected) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic checkCycle();
        int count;
        int pushed;
        int pendPos;
        logic goOn;
        count = modelPc.size();
        checkEqual(validEntryNum, count, "validEntryNum");
        checkEqual(allocatable, (count <= ENTRY_NUM - DISPATCH_WIDTH) && !modelFlush,
                   "allocatable");
        pushed = 0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (dispatchValid[i]) begin
                checkEqual(dispatchIdx[i], (modelTail + pushed) % ENTRY_NUM, "dispatchIdx");
                pushed++;
            end
        end
        // Leading successful entries up to count
        goOn = !modelFlush;
        expPop = 0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i >= count) begin
                goOn = 1'b0;
            end else if (modelState[i] != stateSuccess) begin
                goOn = 1'b0;
            end
            checkEqual(commitValid[i], goOn, "commitValid");
            if (goOn) begin
                checkEqual(commitPc[i], modelPc[i], "commitPc");
                expPop++;
            end
        end
        expFault = 1'b0;
        if (!modelFlush && count > 0) begin
            expFault = modelFault(modelState[0]);
        end
        checkEqual(faultValid, expFault, "faultValid");
        if (expFault) begin
            checkEqual(faultPc, modelPc[0], "faultPc");
            checkEqual(faultState, modelState[0], "faultState");
        end
        // Oldest faulting live entry
        pendPos = -1;
        for (int k = count - 1; k >= 0; k--) begin
            if (modelFault(modelState[k])) begin
                pendPos = k;
            end
        end
        checkEqual(pendingFaultValid, pendPos >= 0, "pendingFaultValid");
        if (pendPos >= 0) begin
            checkEqual(pendingFaultIdx, (modelHead + pendPos) % ENTRY_NUM, "pendingFaultIdx");
        end
    endtask

    task automatic advanceModel();
        int pos;
        if (modelFlush) begin
            modelPc.delete();
            modelState.delete();
            modelTail = modelHead;
            modelFlush = 1'b0;
            flushTotal++;
        end else begin
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wbValid[i]) begin
                    pos = (int'(wbIdx[i]) - modelHead + ENTRY_NUM) % ENTRY_NUM;
                    modelState[pos] = wbState[i];
                end
            end
            repeat (expPop) begin
                void'(modelPc.pop_front());
                void'(modelState.pop_front());
            end
            modelHead = (modelHead + expPop) % ENTRY_NUM;
            commitTotal += expPop;
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (dispatchValid[i]) begin
                    modelPc.push_back(dispatchPc[i]);
                    modelState.push_back(stateNotFinished);
                    modelTail = (modelTail + 1) % ENTRY_NUM;
                end
            end
            modelFlush = expFault;
        end
    endtask

    task automatic chooseStimulus();
        int count;
        int picks [$];
        int r;
        count = modelPc.size();
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (count <= ENTRY_NUM - DISPATCH_WIDTH && !modelFlush
                    && $urandom_range(9, 0) < 6) begin
                dispatchValid[i] <= 1'b1;
                dispatchPc[i] <= nextPc;
                nextPc = nextPc + 32'd4;
            end else begin
                dispatchValid[i] <= 1'b0;
                dispatchPc[i] <= '0;
            end
        end
        // Only live entries that have not finished yet
        for (int k = 0; k < count; k++) begin
            if (modelState[k] == stateNotFinished) begin
                picks.push_back(k);
            end
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            if (picks.size() > 0 && $urandom_range(1, 0) == 1) begin
                r = $urandom_range(picks.size() - 1, 0);
                wbValid[i] <= 1'b1;
                wbIdx[i] <= EntryIdx'((modelHead + picks[r]) % ENTRY_NUM);
                wbState[i] <= pickWbState();
                picks.delete(r);
            end else begin
                wbValid[i] <= 1'b0;
                wbIdx[i] <= '0;
                wbState[i] <= stateNotFinished;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst <= 1'b1;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispatchValid[i] <= 1'b0;
            dispatchPc[i] <= '0;
        end
        for (int i = 0; i < WB_WIDTH; i++) begin
            wbValid[i] <= 1'b0;
            wbIdx[i] <= '0;
            wbState[i] <= stateNotFinished;
        end
        modelHead = 0;
        modelTail = 0;
        modelFlush = 1'b0;
        nextPc = 32'h0000_1000;
        commitTotal = 0;
        flushTotal = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        chooseStimulus();
        for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
            // Outputs are settled half a period after the inputs change
            @(negedge clk);
            checkCycle();
            @(posedge clk);
            advanceModel();
            chooseStimulus();
        end
        $display("Committed %0d entries over %0d flushes", commitTotal, flushTotal);
        checkEqual(flushTotal > 0, 1, "at least one flush");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* activeList.f */
common/activeListCfgPkg.sv
common/activeListOpsPkg.sv
common/activeListIf.sv
activeList/dispatchAllocator.sv
activeList/completionTracker.sv
activeList/commitSelector.sv
source/activeListTop.sv
verif/activeList_checker.sv
verif/activeListTb.sv

/* run.sh */
#!/bin/sh
# Builds the reorder buffer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module activeListTb -f activeList.f -Mdir obj_dir -o activeListSim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/activeListSim > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
    && echo "Test passed" \
    || { echo "Test failed, see sim.log"; exit 1; }
